// ==== files.f ====
+incdir+hw
+incdir+testbench
hw/spu_pkg.sv
hw/spu_op_decode.sv
hw/spu_op_add_sub.sv
hw/spu_op_logic.sv
hw/spu_result_merge.sv
hw/spu_alu_unit.sv
testbench/tb_spu_alu_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_spu_alu_unit -f files.f -o tb_spu_alu_unit

./obj_dir/tb_spu_alu_unit > sim.log 2>&1
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== testbench/spu_alu_ref.svh ====
`ifndef SPU_ALU_REF_SVH
`define SPU_ALU_REF_SVH

// ------------------------------
// expected outputs of one item
// ------------------------------
typedef struct packed {
    logic [`SPU_DATA_BITS-1:0] result;
    logic                      carry_out;
    logic                      msb_carry;
    logic                      zero;
    logic                      negative;
    logic                      overflow;
} ref_out_t;

function automatic ref_out_t alu_ref(input spu_op_t                   op,
                                     input logic [`SPU_DATA_BITS-1:0] a,
                                     input logic [`SPU_DATA_BITS-1:0] b,
                                     input logic                      cin);
    logic [`SPU_DATA_BITS-1:0] b_eff;
    logic [`SPU_DATA_BITS:0]   full;                    // top bit is carry out
    logic [`SPU_DATA_BITS-1:0] low;                     // sum below the MSB
    ref_out_t                  r;
    r = '0;
    case (op)
        ADD, SUB: begin
            b_eff = (op == SUB) ? ~b : b;
            full  = {1'b0, a} + {1'b0, b_eff} + {{`SPU_DATA_BITS{1'b0}}, cin};
            low   = {1'b0, a[`SPU_DATA_BITS-2:0]} + {1'b0, b_eff[`SPU_DATA_BITS-2:0]}
                  + {{(`SPU_DATA_BITS-1){1'b0}}, cin};
            r.result    = full[`SPU_DATA_BITS-1:0];
            r.carry_out = full[`SPU_DATA_BITS];
            r.msb_carry = low[`SPU_DATA_BITS-1];        // carry into the sign bit
            r.overflow  = r.carry_out ^ r.msb_carry;
        end
        AND:     r.result = a & b;
        OR:      r.result = a | b;
        XOR:     r.result = a ^ b;
        default: r.result = '0;                         // CLR
    endcase
    r.zero     = (r.result == '0);
    r.negative = r.result[`SPU_DATA_BITS-1];
    return r;
endfunction

`endif

// ==== testbench/tb_spu_alu_unit.sv ====
`timescale 1ns/100ps

`include "spu_cfg.svh"

module tb_spu_alu_unit
    import spu_pkg::*;
();

    localparam int W            = `SPU_DATA_BITS;
    localparam int LAT          = `SPU_OP_LATENCY;
    localparam int ACCEPT_LIMIT = 100;
    localparam int DRAIN_LIMIT  = 200;

    `include "spu_alu_ref.svh"

    logic         clk;
    logic         reset;
    logic         cke;
    logic         in_valid;
    spu_op_t      op;
    logic [W-1:0] data0;
    logic [W-1:0] data1;
    logic         carry;
    logic         out_valid;
    logic [W-1:0] result;
    logic         carry_out;
    logic         msb_carry;
    logic         zero;
    logic         negative;
    logic         overflow;

    integer   seed = 55653;
    ref_out_t expect_q [$];
    string    test_name;
    int       error_count;
    int       errors_at_start;
    int       items;
    int       pass_tests;
    int       fail_tests;

    spu_alu_unit u_dut (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (in_valid),
        .op        (op),
        .data0     (data0),
        .data1     (data1),
        .carry     (carry),
        .out_valid (out_valid),
        .result    (result),
        .carry_out (carry_out),
        .msb_carry (msb_carry),
        .zero      (zero),
        .negative  (negative),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // scoreboard
    // ------------------------------
    task automatic check_output();
        ref_out_t exp;
        if (expect_q.size() == 0) begin
            $display("%s: result %h arrived with no item pending", test_name, result);
            error_count++;
        end else begin
            exp = expect_q.pop_front();
            if (result !== exp.result) begin
                $display("error %s: result expected %h actual %h", test_name, exp.result, result);
                error_count++;
            end
            if (carry_out !== exp.carry_out) begin
                $display("error %s: carry_out expected %b actual %b", test_name, exp.carry_out,
                         carry_out);
                error_count++;
            end
            if (msb_carry !== exp.msb_carry) begin
                $display("error %s: msb_carry expected %b actual %b", test_name, exp.msb_carry,
                         msb_carry);
                error_count++;
            end
            if (zero !== exp.zero || negative !== exp.negative) begin
                $display("error %s: zero/negative expected %b%b actual %b%b", test_name,
                         exp.zero, exp.negative, zero, negative);
                error_count++;
            end
            if (overflow !== exp.overflow) begin
                $display("error %s: overflow expected %b actual %b", test_name, exp.overflow,
                         overflow);
                error_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset && cke && in_valid) begin
            expect_q.push_back(alu_ref(op, data0, data1, carry));   // accepted item
            items++;
        end
        if (out_valid) begin
            check_output();
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic logic [W-1:0] corner_operand(input int cls);
        logic [31:0]  r;
        logic [W-1:0] one_hot;
        r       = $random(seed);
        one_hot = {{(W-1){1'b0}}, 1'b1} << (r % W);
        case (cls)
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(W-1){1'b0}}};      // signed minimum
            3:       return {1'b0, {(W-1){1'b1}}};      // signed maximum
            4:       return one_hot;
            5:       return ~one_hot;
            default: return r[W-1:0];
        endcase
    endfunction

    function automatic spu_op_t random_op();
        logic [31:0] r;
        r = $random(seed);
        case (r % 5)
            0:       return ADD;
            1:       return SUB;
            2:       return AND;
            3:       return OR;
            default: return XOR;
        endcase
    endfunction

    task automatic send_item(input spu_op_t o, input logic [W-1:0] a, input logic [W-1:0] b,
                             input logic c, input int cke_low_pct, input int gap_pct);
        int   tries;
        logic accepted;
        if (chance(gap_pct)) begin
            @(negedge clk);
            in_valid = 1'b0;                            // idle slot
            cke      = !chance(cke_low_pct);
        end
        accepted = 1'b0;
        tries    = 0;
        while (!accepted && tries < ACCEPT_LIMIT) begin
            @(negedge clk);
            in_valid = 1'b1;
            op       = o;
            data0    = a;
            data1    = b;
            carry    = c;
            cke      = !chance(cke_low_pct);
            accepted = cke;                             // taken at the next rising edge
            tries++;
        end
        if (!accepted) begin
            $display("%s: input item was never accepted", test_name);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        items           = 0;
    endtask

    task automatic finish_test();
        int wait_cycles;
        @(negedge clk);
        in_valid    = 1'b0;
        cke         = 1'b1;
        wait_cycles = 0;
        while (expect_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("%s: %0d results never arrived", test_name, expect_q.size());
            error_count++;
            expect_q.delete();
        end
        repeat (LAT + 4) @(negedge clk);                // anything extra shows up here
        if (error_count == errors_at_start) begin
            pass_tests++;
            $display("test %s: %0d items, pass", test_name, items);
        end else begin
            fail_tests++;
            $display("test %s: %0d items, %0d errors, fail", test_name, items,
                     error_count - errors_at_start);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic add_sub_test();
        spu_op_t o;
        begin_test("add_sub_corners");
        for (int k = 0; k < 2; k++) begin
            o = (k == 0) ? ADD : SUB;
            for (int i = 0; i < 7; i++) begin
                for (int j = 0; j < 7; j++) begin
                    for (int c = 0; c < 2; c++) begin
                        send_item(o, corner_operand(i), corner_operand(j), c[0], 10, 30);
                    end
                end
            end
        end
        finish_test();
    endtask

    task automatic logic_test();
        logic [31:0] r;
        spu_op_t     o;
        begin_test("logic_ops");
        for (int n = 0; n < 150; n++) begin
            r = $random(seed);
            case (r % 3)
                0:       o = AND;
                1:       o = OR;
                default: o = XOR;
            endcase
            send_item(o, corner_operand(6), corner_operand(6), r[8], 10, 30);
        end
        finish_test();
    endtask

    task automatic clear_test(input string name, input int count, input int clr_pct,
                              input int cke_low_pct, input int gap_pct);
        logic [31:0] r;
        spu_op_t     o;
        begin_test(name);
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            o = chance(clr_pct) ? CLR : random_op();
            send_item(o, corner_operand(int'(r[3:0]) % 7), corner_operand(int'(r[7:4]) % 7),
                      r[8], cke_low_pct, gap_pct);
        end
        finish_test();
    endtask

    task automatic latency_test();
        int lat;
        bit seen;
        begin_test("latency");
        repeat (2) begin
            @(negedge clk);
            in_valid = 1'b1;                            // still in flight when reset hits
            op       = random_op();
            data0    = corner_operand(6);
            data1    = corner_operand(6);
            cke      = 1'b1;
        end
        @(negedge clk);
        reset    = 1'b1;
        in_valid = 1'b0;
        cke      = 1'b1;
        expect_q.delete();                              // reset discards them
        repeat (12) begin
            @(negedge clk);
            reset = (lat < 7);                          // 8 cycles in reset, then idle
            lat++;
            if (out_valid) begin
                $display("latency: out_valid high after reset before any new item");
                error_count++;
            end
        end
        in_valid = 1'b1;
        op       = ADD;
        data0    = corner_operand(6);
        data1    = corner_operand(6);
        carry    = 1'b0;
        seen     = 1'b0;
        @(negedge clk);                                 // accepting edge is the first
        in_valid = 1'b0;
        lat      = 1;
        while (!seen && lat < DRAIN_LIMIT) begin
            if (out_valid) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                lat++;
            end
        end
        if (!seen) begin
            $display("latency: no result within %0d cycles", DRAIN_LIMIT);
            error_count++;
        end else if (lat != LAT + 2) begin
            $display("error latency: cycles expected %0d actual %0d", LAT + 2, lat);
            error_count++;
        end
        finish_test();
    endtask

    initial begin
        reset    = 1'b1;
        cke      = 1'b1;
        in_valid = 1'b0;
        op       = ADD;
        data0    = '0;
        data1    = '0;
        carry    = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        add_sub_test();
        logic_test();
        clear_test("clear_mix", 120, 35, 10, 30);
        clear_test("stall_stream", 300, 15, 20, 0);     // back-to-back items
        latency_test();

        $display("tests passed %0d failed %0d, errors %0d", pass_tests, fail_tests,
                 error_count);
        if (fail_tests == 0 && error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/spu_alu_unit.sv ====
`timescale 1ns/100ps

`include "spu_cfg.svh"

module spu_alu_unit
    import spu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cke,
    input  logic                      in_valid,
    input  spu_op_t                   op,
    input  logic [`SPU_DATA_BITS-1:0] data0,
    input  logic [`SPU_DATA_BITS-1:0] data1,
    input  logic                      carry,
    output logic                      out_valid,
    output logic [`SPU_DATA_BITS-1:0] result,
    output logic                      carry_out,
    output logic                      msb_carry,
    output logic                      zero,
    output logic                      negative,
    output logic                      overflow
);

    // ------------------------------
    // decode to operators
    // ------------------------------
    logic                      op_valid;
    logic                      op_sub;
    logic                      op_clear;
    spu_logic_fn_t             logic_fn;
    spu_sel_t                  op_sel;
    logic [`SPU_DATA_BITS-1:0] data0_d;
    logic [`SPU_DATA_BITS-1:0] data1_d;
    logic                      carry_d;

    // operators to merge
    logic                      arith_valid;
    logic                      arith_carry;
    logic                      arith_msb_c;
    logic [`SPU_DATA_BITS-1:0] arith_data;
    logic [`SPU_DATA_BITS-1:0] logic_data;

    spu_op_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .in_valid (in_valid),
        .op       (op),
        .data0    (data0),
        .data1    (data1),
        .carry    (carry),
        .op_valid (op_valid),
        .op_sub   (op_sub),
        .op_clear (op_clear),
        .logic_fn (logic_fn),
        .op_sel   (op_sel),
        .data0_d  (data0_d),
        .data1_d  (data1_d),
        .carry_d  (carry_d)
    );

    spu_op_add_sub #(
        .DATA_BITS (`SPU_DATA_BITS),
        .LATENCY   (`SPU_OP_LATENCY)
    ) u_add_sub (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .valid   (op_valid),
        .sub     (op_sub),
        .clear   (op_clear),
        .carry   (carry_d),
        .data0   (data0_d),
        .data1   (data1_d),
        .m_valid (arith_valid),
        .m_carry (arith_carry),
        .m_msb_c (arith_msb_c),
        .m_data  (arith_data)
    );

    spu_op_logic #(
        .DATA_BITS (`SPU_DATA_BITS),
        .LATENCY   (`SPU_OP_LATENCY)
    ) u_logic (
        .clk    (clk),
        .reset  (reset),
        .cke    (cke),
        .fn     (logic_fn),
        .clear  (op_clear),
        .data0  (data0_d),
        .data1  (data1_d),
        .m_data (logic_data)
    );

    spu_result_merge u_merge (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .sel         (op_sel),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .arith_carry (arith_carry),
        .arith_msb_c (arith_msb_c),
        .logic_data  (logic_data),
        .out_valid   (out_valid),
        .result      (result),
        .carry_out   (carry_out),
        .msb_carry   (msb_carry),
        .zero        (zero),
        .negative    (negative),
        .overflow    (overflow)
    );

endmodule

// ==== hw/spu_result_merge.sv ====
`timescale 1ns/100ps

`include "spu_cfg.svh"

module spu_result_merge
    import spu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cke,
    input  spu_sel_t                  sel,
    input  logic                      arith_valid,
    input  logic [`SPU_DATA_BITS-1:0] arith_data,
    input  logic                      arith_carry,
    input  logic                      arith_msb_c,
    input  logic [`SPU_DATA_BITS-1:0] logic_data,
    output logic                      out_valid,
    output logic [`SPU_DATA_BITS-1:0] result,
    output logic                      carry_out,
    output logic                      msb_carry,
    output logic                      zero,
    output logic                      negative,
    output logic                      overflow
);

    localparam int SEL_DELAY = `SPU_OP_LATENCY;

    spu_sel_t                  sel_pipe [SEL_DELAY];
    spu_sel_t                  sel_q;
    logic [`SPU_DATA_BITS-1:0] next_result;
    logic                      next_carry;
    logic                      next_msb_c;
    logic                      next_overflow;
    logic                      valid_q;

    // ------------------------------
    // select alignment
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SEL_DELAY; i++) begin
                sel_pipe[i] <= ARITH;
            end
        end else if (cke) begin
            sel_pipe[0] <= sel;
            for (int i = 1; i < SEL_DELAY; i++) begin
                sel_pipe[i] <= sel_pipe[i-1];
            end
        end
    end

    assign sel_q = sel_pipe[SEL_DELAY-1];

    // ------------------------------
    // result and flags
    // ------------------------------
    always_comb begin
        if (sel_q == ARITH) begin
            next_result   = arith_data;
            next_carry    = arith_carry;
            next_msb_c    = arith_msb_c;
            next_overflow = arith_carry ^ arith_msb_c;  // signed overflow
        end else begin
            next_result   = logic_data;
            next_carry    = 1'b0;
            next_msb_c    = 1'b0;
            next_overflow = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            result    <= '0;
            carry_out <= 1'b0;
            msb_carry <= 1'b0;
            zero      <= 1'b0;
            negative  <= 1'b0;
            overflow  <= 1'b0;
        end else if (cke) begin
            valid_q   <= arith_valid;           // both blocks share valid
            result    <= next_result;
            carry_out <= next_carry;
            msb_carry <= next_msb_c;
            zero      <= (next_result == '0);
            negative  <= next_result[`SPU_DATA_BITS-1];
            overflow  <= next_overflow;
        end
    end

    // one visible cycle per item even across stalls
    assign out_valid = valid_q & cke;

endmodule

// ==== hw/spu_op_logic.sv ====
`timescale 1ns/100ps

`include "spu_cfg.svh"

module spu_op_logic
    import spu_pkg::*;
#(
    parameter int DATA_BITS = `SPU_DATA_BITS,
    parameter int LATENCY   = `SPU_OP_LATENCY
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cke,
    input  spu_logic_fn_t        fn,
    input  logic                 clear,
    input  logic [DATA_BITS-1:0] data0,
    input  logic [DATA_BITS-1:0] data1,
    output logic [DATA_BITS-1:0] m_data
);

    logic [DATA_BITS-1:0] next_data;
    logic [DATA_BITS-1:0] data_pipe [LATENCY];

    // ------------------------------
    // bitwise function
    // ------------------------------
    always_comb begin
        case (fn)
            FN_AND:  next_data = data0 & data1;
            FN_OR:   next_data = data0 | data1;
            FN_XOR:  next_data = data0 ^ data1;
            default: next_data = '0;
        endcase
        if (clear) begin
            next_data = '0;
        end
    end

    // same depth as the adder so results line up
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                data_pipe[i] <= '0;
            end
        end else if (cke) begin
            data_pipe[0] <= next_data;
            for (int i = 1; i < LATENCY; i++) begin
                data_pipe[i] <= data_pipe[i-1];
            end
        end
    end

    assign m_data = data_pipe[LATENCY-1];

endmodule

// ==== hw/spu_op_add_sub.sv ====
`timescale 1ns/100ps

`include "spu_cfg.svh"

module spu_op_add_sub #(
    parameter int DATA_BITS = `SPU_DATA_BITS,
    parameter int LATENCY   = `SPU_OP_LATENCY
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cke,
    input  logic                 valid,
    input  logic                 sub,
    input  logic                 clear,
    input  logic                 carry,
    input  logic [DATA_BITS-1:0] data0,
    input  logic [DATA_BITS-1:0] data1,
    output logic                 m_valid,
    output logic                 m_carry,
    output logic                 m_msb_c,
    output logic [DATA_BITS-1:0] m_data
);

    logic [DATA_BITS-1:0] operand1;
    logic [DATA_BITS:0]   sum_full;             // extra bit holds carry out
    logic [DATA_BITS-1:0] next_data;
    logic                 next_carry;
    logic                 next_msb_c;

    logic [DATA_BITS-1:0] data_pipe [LATENCY];
    logic [LATENCY-1:0]   valid_pipe;
    logic [LATENCY-1:0]   carry_pipe;
    logic [LATENCY-1:0]   msb_pipe;

    // ------------------------------
    // adder
    // ------------------------------
    always_comb begin
        operand1 = sub ? ~data1 : data1;
        sum_full = {1'b0, data0} + {1'b0, operand1} + {{DATA_BITS{1'b0}}, carry};

        // carry into the top bit recovered from the top sum bit
        next_msb_c = data0[DATA_BITS-1] ^ operand1[DATA_BITS-1] ^ sum_full[DATA_BITS-1];
        next_carry = sum_full[DATA_BITS];
        next_data  = sum_full[DATA_BITS-1:0];

        if (clear) begin
            next_data  = '0;
            next_carry = 1'b0;
            next_msb_c = 1'b0;
        end
    end

    // ------------------------------
    // shift pipeline
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
            carry_pipe <= '0;
            msb_pipe   <= '0;
            for (int i = 0; i < LATENCY; i++) begin
                data_pipe[i] <= '0;
            end
        end else if (cke) begin
            valid_pipe[0] <= valid;             // first stage takes the sum
            carry_pipe[0] <= next_carry;
            msb_pipe[0]   <= next_msb_c;
            data_pipe[0]  <= next_data;
            for (int i = 1; i < LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
                carry_pipe[i] <= carry_pipe[i-1];
                msb_pipe[i]   <= msb_pipe[i-1];
                data_pipe[i]  <= data_pipe[i-1];
            end
        end
    end

    assign m_valid = valid_pipe[LATENCY-1];
    assign m_carry = carry_pipe[LATENCY-1];
    assign m_msb_c = msb_pipe[LATENCY-1];
    assign m_data  = data_pipe[LATENCY-1];

endmodule

// ==== hw/spu_op_decode.sv ====
`timescale 1ns/100ps

`include "spu_cfg.svh"

module spu_op_decode
    import spu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cke,
    input  logic                      in_valid,
    input  spu_op_t                   op,
    input  logic [`SPU_DATA_BITS-1:0] data0,
    input  logic [`SPU_DATA_BITS-1:0] data1,
    input  logic                      carry,
    output logic                      op_valid,
    output logic                      op_sub,
    output logic                      op_clear,
    output spu_logic_fn_t             logic_fn,
    output spu_sel_t                  op_sel,
    output logic [`SPU_DATA_BITS-1:0] data0_d,
    output logic [`SPU_DATA_BITS-1:0] data1_d,
    output logic                      carry_d
);

    logic          next_sub;
    logic          next_clear;
    spu_logic_fn_t next_fn;
    spu_sel_t      next_sel;
    logic          next_carry;

    // ------------------------------
    // opcode translation
    // ------------------------------
    always_comb begin
        next_sub   = 1'b0;
        next_clear = 1'b0;
        next_fn    = FN_AND;
        next_sel   = ARITH;
        next_carry = carry;
        case (op)
            ADD: begin
                next_sel = ARITH;
            end
            SUB: begin
                next_sub = 1'b1;                // invert operand 1
            end
            AND: begin
                next_fn    = FN_AND;
                next_sel   = LOGIC;
                next_carry = 1'b0;              // no carry out of bitwise ops
            end
            OR: begin
                next_fn    = FN_OR;
                next_sel   = LOGIC;
                next_carry = 1'b0;
            end
            XOR: begin
                next_fn    = FN_XOR;
                next_sel   = LOGIC;
                next_carry = 1'b0;
            end
            CLR: begin
                next_clear = 1'b1;              // adder path emits zeros
            end
            default: begin
                next_clear = 1'b1;              // unknown codes behave as CLR
            end
        endcase
    end

    // ------------------------------
    // decode register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
            op_sub   <= 1'b0;
            op_clear <= 1'b0;
            logic_fn <= FN_AND;
            op_sel   <= ARITH;
            data0_d  <= '0;
            data1_d  <= '0;
            carry_d  <= 1'b0;
        end else if (cke) begin
            op_valid <= in_valid;               // accept on strobe
            op_sub   <= next_sub;
            op_clear <= next_clear;
            logic_fn <= next_fn;
            op_sel   <= next_sel;
            data0_d  <= data0;
            data1_d  <= data1;
            carry_d  <= next_carry;
        end
    end

endmodule

// ==== hw/spu_pkg.sv ====
package spu_pkg;

    // ------------------------------
    // opcodes
    // ------------------------------
    typedef enum logic [2:0] {
        ADD = 3'd0,                             // data0 + data1 + carry
        SUB = 3'd1,                             // data0 + ~data1 + carry
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        CLR = 3'd5                              // zero result and carries
    } spu_op_t;

    // ------------------------------
    // operator controls
    // ------------------------------
    typedef enum logic {
        ARITH = 1'b0,                           // add/sub block
        LOGIC = 1'b1                            // bitwise block
    } spu_sel_t;

    typedef enum logic [1:0] {
        FN_AND = 2'd0,
        FN_OR  = 2'd1,
        FN_XOR = 2'd2
    } spu_logic_fn_t;

endpackage

// ==== hw/spu_cfg.svh ====
`ifndef SPU_CFG_SVH
`define SPU_CFG_SVH

// ------------------------------
// datapath configuration
// ------------------------------

// operand and result width
`define SPU_DATA_BITS 16

// register stages inside each operator block, at least 1
`define SPU_OP_LATENCY 2

`endif
